// File: logic/sram_test_pkg.sv
// shared widths, chip numbering and register map of the SRAM test harness
// chips 5 to 7 are decoded as empty, so accesses to them capture zero
// every macro address is 10 bits wide, smaller chips ignore the upper bits
`default_nettype none

package sram_test_pkg;

   // bus and macro widths
   localparam int data_w     = 32;
   localparam int addr_w     = 10;
   localparam int mask_w     = 4;
   localparam int chip_w     = 3;
   localparam int apb_addr_w = 12;

   // chips 0 to 4 are populated
   localparam int chip_count = 5;

   typedef logic [data_w-1:0]   data_t;
   typedef logic [addr_w-1:0]   sram_addr_t;
   typedef logic [mask_w-1:0]   wmask_t;
   typedef logic [chip_w-1:0]   chip_t;
   typedef logic [2*data_w-1:0] wide_word_t;

   // register offsets
   localparam logic [apb_addr_w-1:0] reg_addr_off   = 12'h000;
   localparam logic [apb_addr_w-1:0] reg_din_off    = 12'h004;
   localparam logic [apb_addr_w-1:0] reg_ctrl_off   = 12'h008;
   localparam logic [apb_addr_w-1:0] reg_cmd_off    = 12'h00C;
   localparam logic [apb_addr_w-1:0] reg_status_off = 12'h010;
   localparam logic [apb_addr_w-1:0] reg_dout0_off  = 12'h014;
   localparam logic [apb_addr_w-1:0] reg_dout1_off  = 12'h018;

   // field positions
   localparam int addr1_lsb       = 16;
   localparam int ctrl_mask_lsb   = 0;
   localparam int ctrl_read_bit   = 4;
   localparam int ctrl_chip_lsb   = 8;
   localparam int status_busy_bit = 0;

endpackage

`default_nettype wire

// File: logic/sram_1rw1r.sv
// behavioral dual-port macro, 32-bit word with a 4-bit byte mask
// contents are not reset, outputs hold their value between reads
// a port 1 read of an address written in the same cycle gives the old word
`timescale 1ns/1ps
`default_nettype none

module sram_1rw1r
   import sram_test_pkg::*;
#(
   parameter int DEPTH = 256
) (
   input  logic       sram_clk,
   // read/write port
   input  logic       csb0_i,
   input  logic       web0_i,
   input  wmask_t     wmask0_i,
   input  sram_addr_t addr0_i,
   input  data_t      din0_i,
   output data_t      dout0_o,
   // read-only port
   input  logic       csb1_i,
   input  sram_addr_t addr1_i,
   output data_t      dout1_o
);

   localparam int aw = $clog2(DEPTH);

   data_t mem [DEPTH];

   // port 0, masked write or registered read
   always_ff @(posedge sram_clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < mask_w; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i[aw-1:0]][8*b +: 8] <= din0_i[8*b +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i[aw-1:0]];
         end
      end
   end

   // port 1 sees the contents before this edge's write
   always_ff @(posedge sram_clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i[aw-1:0]];
      end
   end

endmodule

`default_nettype wire

// File: logic/sram_1rw.sv
// behavioral single-port macro, word width taken from word_t
// word_t must be a packed vector of whole bytes
// contents are not reset, the output holds its value between reads
`timescale 1ns/1ps
`default_nettype none

module sram_1rw
   import sram_test_pkg::*;
#(
   parameter int  DEPTH  = 256,
   parameter type word_t = data_t
) (
   input  logic                         sram_clk,
   input  logic                         csb0_i,
   input  logic                         web0_i,
   input  logic [$bits(word_t)/8-1:0]   wmask0_i,
   input  sram_addr_t                   addr0_i,
   input  word_t                        din0_i,
   output word_t                        dout0_o
);

   localparam int aw     = $clog2(DEPTH);
   localparam int nbytes = $bits(word_t) / 8;

   word_t mem [DEPTH];

   always_ff @(posedge sram_clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // only the masked bytes change
            for (int b = 0; b < nbytes; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i[aw-1:0]][8*b +: 8] <= din0_i[8*b +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i[aw-1:0]];
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/sram_dual_bank.sv
// the three dual-port chips on shared address and data buses
// outputs are valid in the cycle after a request and zero for other banks
// chip 0 is 8 bits wide, only byte 0 is written and read back
`timescale 1ns/1ps
`default_nettype none

module sram_dual_bank
   import sram_test_pkg::*;
#(
   parameter int CHIP_BASE = 0
) (
   input  logic       sram_clk,
   input  logic       resetn,
   input  logic       acc_req_i,
   input  chip_t      acc_chip_i,
   input  logic       acc_read_i,
   input  sram_addr_t acc_addr0_i,
   input  sram_addr_t acc_addr1_i,
   input  data_t      acc_din_i,
   input  wmask_t     acc_wmask_i,
   output data_t      dout0_o,
   output data_t      dout1_o
);

   localparam int n_chips = 3;

   logic [n_chips-1:0] sel;
   logic [n_chips-1:0] hit_q;
   logic               read_q;
   data_t              c0_dout0;
   data_t              c0_dout1;
   data_t              chip_dout0 [n_chips];
   data_t              chip_dout1 [n_chips];

   // chip decode, active only during the request cycle
   always_comb begin
      for (int k = 0; k < n_chips; k++) begin
         sel[k] = acc_req_i && (acc_chip_i == chip_t'(CHIP_BASE + k));
      end
   end

   // which chip answered, used to pick outputs one cycle later
   always_ff @(posedge sram_clk) begin
      if (!resetn) begin
         hit_q  <= '0;
         read_q <= 1'b0;
      end else if (acc_req_i) begin
         hit_q  <= sel;
         read_q <= acc_read_i;
      end
   end

   sram_1rw1r #(.DEPTH(1024)) chip0_i (
      .sram_clk (sram_clk),
      .csb0_i   (!sel[0]),
      .web0_i   (acc_read_i),
      .wmask0_i ({3'b000, acc_wmask_i[0]}),
      .addr0_i  (acc_addr0_i),
      .din0_i   (acc_din_i),
      .dout0_o  (c0_dout0),
      .csb1_i   (!sel[0]),
      .addr1_i  (acc_addr1_i),
      .dout1_o  (c0_dout1)
   );

   // narrow chip, zero-extend byte 0
   assign chip_dout0[0] = {24'd0, c0_dout0[7:0]};
   assign chip_dout1[0] = {24'd0, c0_dout1[7:0]};

   sram_1rw1r #(.DEPTH(256)) chip1_i (
      .sram_clk (sram_clk),
      .csb0_i   (!sel[1]),
      .web0_i   (acc_read_i),
      .wmask0_i (acc_wmask_i),
      .addr0_i  (acc_addr0_i),
      .din0_i   (acc_din_i),
      .dout0_o  (chip_dout0[1]),
      .csb1_i   (!sel[1]),
      .addr1_i  (acc_addr1_i),
      .dout1_o  (chip_dout1[1])
   );

   sram_1rw1r #(.DEPTH(512)) chip2_i (
      .sram_clk (sram_clk),
      .csb0_i   (!sel[2]),
      .web0_i   (acc_read_i),
      .wmask0_i (acc_wmask_i),
      .addr0_i  (acc_addr0_i),
      .din0_i   (acc_din_i),
      .dout0_o  (chip_dout0[2]),
      .csb1_i   (!sel[2]),
      .addr1_i  (acc_addr1_i),
      .dout1_o  (chip_dout1[2])
   );

   // port 0 only reports on reads, port 1 reads on every access
   always_comb begin
      dout0_o = '0;
      dout1_o = '0;
      for (int k = 0; k < n_chips; k++) begin
         if (hit_q[k]) begin
            dout0_o = dout0_o | (read_q ? chip_dout0[k] : '0);
            dout1_o = dout1_o | chip_dout1[k];
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/sram_single_bank.sv
// the two single-port chips, chip 3 of 32 bits and chip 4 of 64 bits
// chip 4 stores data bits 31:16 in bytes 7:6 and 15:0 in bytes 1:0
// bytes 5:2 of chip 4 are written as zero, dout1_o is always zero
`timescale 1ns/1ps
`default_nettype none

module sram_single_bank
   import sram_test_pkg::*;
#(
   parameter int CHIP_BASE = 3
) (
   input  logic       sram_clk,
   input  logic       resetn,
   input  logic       acc_req_i,
   input  chip_t      acc_chip_i,
   input  logic       acc_read_i,
   input  sram_addr_t acc_addr0_i,
   input  sram_addr_t acc_addr1_i,
   input  data_t      acc_din_i,
   input  wmask_t     acc_wmask_i,
   output data_t      dout0_o,
   output data_t      dout1_o
);

   // this bank runs up to the last populated chip
   localparam int n_chips    = chip_count - CHIP_BASE;
   localparam int wide_bytes = $bits(wide_word_t) / 8;

   logic [n_chips-1:0]    sel;
   logic [n_chips-1:0]    hit_q;
   logic                  read_q;
   data_t                 c3_dout0;
   wide_word_t            c4_din;
   wide_word_t            c4_dout0;
   logic [wide_bytes-1:0] c4_wmask;

   always_comb begin
      for (int k = 0; k < n_chips; k++) begin
         sel[k] = acc_req_i && (acc_chip_i == chip_t'(CHIP_BASE + k));
      end
   end

   always_ff @(posedge sram_clk) begin
      if (!resetn) begin
         hit_q  <= '0;
         read_q <= 1'b0;
      end else if (acc_req_i) begin
         hit_q  <= sel;
         read_q <= acc_read_i;
      end
   end

   sram_1rw #(.DEPTH(256), .word_t(data_t)) chip3_i (
      .sram_clk (sram_clk),
      .csb0_i   (!sel[0]),
      .web0_i   (acc_read_i),
      .wmask0_i (acc_wmask_i),
      .addr0_i  (acc_addr0_i),
      .din0_i   (acc_din_i),
      .dout0_o  (c3_dout0)
   );

   // split the 32-bit word across both ends of the wide word
   assign c4_din   = {acc_din_i[31:16], 32'd0, acc_din_i[15:0]};
   assign c4_wmask = {acc_wmask_i[3:2], 4'b0000, acc_wmask_i[1:0]};

   sram_1rw #(.DEPTH(512), .word_t(wide_word_t)) chip4_i (
      .sram_clk (sram_clk),
      .csb0_i   (!sel[1]),
      .web0_i   (acc_read_i),
      .wmask0_i (c4_wmask),
      .addr0_i  (acc_addr0_i),
      .din0_i   (c4_din),
      .dout0_o  (c4_dout0)
   );

   always_comb begin
      dout0_o = '0;
      if (read_q && hit_q[0]) begin
         dout0_o = c3_dout0;
      end else if (read_q && hit_q[1]) begin
         // repack both kept halves
         dout0_o = {c4_dout0[63:48], c4_dout0[15:0]};
      end
   end

   // no second port, the port 1 address has nowhere to go
   assign dout1_o = '0;

endmodule

`default_nettype wire

// File: logic/sram_apb_regs.sv
// APB register block, no wait states, pready_o is tied high
// a CMD write starts one access, results are captured two cycles later
// pslverr_o flags unmapped offsets and CMD writes while busy
`timescale 1ns/1ps
`default_nettype none

module sram_apb_regs
   import sram_test_pkg::*;
(
   input  logic                  sram_clk,
   input  logic                  resetn,
   // APB slave
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [apb_addr_w-1:0] paddr_i,
   input  data_t                 pwdata_i,
   output data_t                 prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   // bank results
   input  data_t                 left_dout0_i,
   input  data_t                 left_dout1_i,
   input  data_t                 right_dout0_i,
   input  data_t                 right_dout1_i,
   // access to both banks
   output logic                  acc_req_o,
   output chip_t                 acc_chip_o,
   output logic                  acc_read_o,
   output sram_addr_t            acc_addr0_o,
   output sram_addr_t            acc_addr1_o,
   output data_t                 acc_din_o,
   output wmask_t                acc_wmask_o
);

   logic       access;
   logic       mapped;
   logic       cmd_wr;
   logic       err;
   logic       wr_en;
   logic       cmd_go;
   logic       busy_q;
   logic       req_q;
   logic       wait_q;
   sram_addr_t addr0_q;
   sram_addr_t addr1_q;
   data_t      din_q;
   wmask_t     wmask_q;
   logic       read_q;
   chip_t      chip_q;
   data_t      dout0_q;
   data_t      dout1_q;

   assign access = psel_i && penable_i;

   always_comb begin
      mapped = paddr_i inside {reg_addr_off, reg_din_off, reg_ctrl_off, reg_cmd_off,
                               reg_status_off, reg_dout0_off, reg_dout1_off};
   end

   assign cmd_wr    = pwrite_i && (paddr_i == reg_cmd_off);
   assign err       = !mapped || (cmd_wr && busy_q);
   assign pslverr_o = access && err;
   assign pready_o  = 1'b1;
   assign wr_en     = access && pwrite_i && !err;
   assign cmd_go    = wr_en && cmd_wr;

   always_ff @(posedge sram_clk) begin
      if (!resetn) begin
         busy_q  <= 1'b0;
         req_q   <= 1'b0;
         wait_q  <= 1'b0;
         dout0_q <= '0;
         dout1_q <= '0;
         addr0_q <= '0;
         addr1_q <= '0;
         din_q   <= '0;
         wmask_q <= '0;
         read_q  <= 1'b0;
         chip_q  <= '0;
      end else begin
         // request in the cycle after the CMD write, capture one cycle later
         req_q  <= cmd_go;
         wait_q <= req_q;
         if (cmd_go) begin
            busy_q <= 1'b1;
         end else if (wait_q) begin
            busy_q <= 1'b0;
         end
         if (wait_q) begin
            dout0_q <= left_dout0_i | right_dout0_i;
            dout1_q <= left_dout1_i | right_dout1_i;
         end
         if (wr_en) begin
            case (paddr_i)
               reg_addr_off: begin
                  addr0_q <= pwdata_i[addr_w-1:0];
                  addr1_q <= pwdata_i[addr1_lsb +: addr_w];
               end
               reg_din_off: begin
                  din_q <= pwdata_i;
               end
               reg_ctrl_off: begin
                  wmask_q <= pwdata_i[ctrl_mask_lsb +: mask_w];
                  read_q  <= pwdata_i[ctrl_read_bit];
                  chip_q  <= pwdata_i[ctrl_chip_lsb +: chip_w];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // read mux, CMD reads as zero
   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         reg_addr_off: begin
            prdata_o[addr_w-1:0]          = addr0_q;
            prdata_o[addr1_lsb +: addr_w] = addr1_q;
         end
         reg_din_off: begin
            prdata_o = din_q;
         end
         reg_ctrl_off: begin
            prdata_o[ctrl_mask_lsb +: mask_w] = wmask_q;
            prdata_o[ctrl_read_bit]           = read_q;
            prdata_o[ctrl_chip_lsb +: chip_w] = chip_q;
         end
         reg_status_off: begin
            prdata_o[status_busy_bit] = busy_q;
         end
         reg_dout0_off: begin
            prdata_o = dout0_q;
         end
         reg_dout1_off: begin
            prdata_o = dout1_q;
         end
         default: begin
         end
      endcase
   end

   assign acc_req_o   = req_q;
   assign acc_chip_o  = chip_q;
   assign acc_read_o  = read_q;
   assign acc_addr0_o = addr0_q;
   assign acc_addr1_o = addr1_q;
   assign acc_din_o   = din_q;
   assign acc_wmask_o = wmask_q;

endmodule

`default_nettype wire

// File: logic/sram_test_top.sv
// SRAM test harness, APB register block driving both memory banks
// one clock for the bus and the macros, reset is synchronous active low
`timescale 1ns/1ps
`default_nettype none

module sram_test_top
   import sram_test_pkg::*;
(
   input  logic                  sram_clk,
   input  logic                  resetn,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [apb_addr_w-1:0] paddr_i,
   input  data_t                 pwdata_i,
   output data_t                 prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o
);

   logic       acc_req;
   chip_t      acc_chip;
   logic       acc_read;
   sram_addr_t acc_addr0;
   sram_addr_t acc_addr1;
   data_t      acc_din;
   wmask_t     acc_wmask;
   data_t      left_dout0;
   data_t      left_dout1;
   data_t      right_dout0;
   data_t      right_dout1;

   sram_apb_regs regs_i (
      .sram_clk      (sram_clk),
      .resetn        (resetn),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .paddr_i       (paddr_i),
      .pwdata_i      (pwdata_i),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .left_dout0_i  (left_dout0),
      .left_dout1_i  (left_dout1),
      .right_dout0_i (right_dout0),
      .right_dout1_i (right_dout1),
      .acc_req_o     (acc_req),
      .acc_chip_o    (acc_chip),
      .acc_read_o    (acc_read),
      .acc_addr0_o   (acc_addr0),
      .acc_addr1_o   (acc_addr1),
      .acc_din_o     (acc_din),
      .acc_wmask_o   (acc_wmask)
   );

   // chips 0 to 2
   sram_dual_bank #(.CHIP_BASE(0)) left_i (
      .sram_clk    (sram_clk),
      .resetn      (resetn),
      .acc_req_i   (acc_req),
      .acc_chip_i  (acc_chip),
      .acc_read_i  (acc_read),
      .acc_addr0_i (acc_addr0),
      .acc_addr1_i (acc_addr1),
      .acc_din_i   (acc_din),
      .acc_wmask_i (acc_wmask),
      .dout0_o     (left_dout0),
      .dout1_o     (left_dout1)
   );

   // chips 3 and 4
   sram_single_bank #(.CHIP_BASE(3)) right_i (
      .sram_clk    (sram_clk),
      .resetn      (resetn),
      .acc_req_i   (acc_req),
      .acc_chip_i  (acc_chip),
      .acc_read_i  (acc_read),
      .acc_addr0_i (acc_addr0),
      .acc_addr1_i (acc_addr1),
      .acc_din_i   (acc_din),
      .acc_wmask_i (acc_wmask),
      .dout0_o     (right_dout0),
      .dout1_o     (right_dout1)
   );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// clock and reset source for the SRAM harness testbench
// 10 ns clock, resetn low for the first 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic sram_clk_o,
   output logic resetn_o
);

   initial begin
      sram_clk_o = 1'b0;
      forever #5 sram_clk_o = ~sram_clk_o;
   end

   // released on the 8th edge, so the DUT sees reset at 8 edges
   initial begin
      resetn_o = 1'b0;
      repeat (8) @(posedge sram_clk_o);
      resetn_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: verif/sram_test_sva.sv
// concurrent checks on the APB register block, bound into sram_apb_regs
// all properties are disabled while resetn is low
`timescale 1ns/1ps
`default_nettype none

module sram_test_sva
   import sram_test_pkg::*;
(
   input logic                  sram_clk,
   input logic                  resetn,
   input logic                  psel_i,
   input logic                  penable_i,
   input logic                  pwrite_i,
   input logic [apb_addr_w-1:0] paddr_i,
   input logic                  pready_i,
   input logic                  pslverr_i,
   input logic                  acc_req_i,
   input logic                  busy_i
);

   logic cmd_ok;

   // CMD write accepted in its access phase
   assign cmd_ok = psel_i && penable_i && pwrite_i && (paddr_i == reg_cmd_off) && !pslverr_i;

   a_pready_high: assert property (@(posedge sram_clk) disable iff (!resetn) pready_i)
      else $error("pready_o went low");

   a_req_after_cmd: assert property (@(posedge sram_clk) disable iff (!resetn)
      cmd_ok |=> acc_req_i)
      else $error("no access request after an accepted CMD write");

   a_req_has_cmd: assert property (@(posedge sram_clk) disable iff (!resetn)
      acc_req_i |-> $past(cmd_ok))
      else $error("access request without a CMD write one cycle before");

   a_req_single: assert property (@(posedge sram_clk) disable iff (!resetn)
      acc_req_i |=> !acc_req_i)
      else $error("access request longer than one cycle");

   // busy lasts exactly two cycles
   a_busy_limit: assert property (@(posedge sram_clk) disable iff (!resetn)
      (busy_i && $past(busy_i)) |=> !busy_i)
      else $error("busy stayed set longer than two cycles");

   a_busy_clear: assert property (@(posedge sram_clk) disable iff (!resetn)
      $fell(busy_i) |-> ($past(busy_i, 2) && !$past(busy_i, 3)))
      else $error("busy did not last exactly two cycles");

endmodule

bind sram_apb_regs sram_test_sva sva_i (
   .sram_clk  (sram_clk),
   .resetn    (resetn),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pwrite_i  (pwrite_i),
   .paddr_i   (paddr_i),
   .pready_i  (pready_o),
   .pslverr_i (pslverr_o),
   .acc_req_i (acc_req_o),
   .busy_i    (busy_q)
);

`default_nettype wire

// File: verif/sram_test_tb.sv
// testbench for the SRAM harness, vectors come from verif/sram_test_input.txt
// run from the project root, stops at the first mismatch
// op 0 write, 1 read, 2 write with DOUT1 unchecked, 3 read with a CMD while busy
`timescale 1ns/1ps
`default_nettype none

module sram_test_tb
   import sram_test_pkg::*;
();

   localparam int reset_limit = 50;
   localparam int ready_limit = 8;
   localparam int poll_limit  = 20;

   logic                  sram_clk;
   logic                  resetn;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   data_t                 pwdata;
   data_t                 prdata;
   logic                  pready;
   logic                  pslverr;

   tb_clk_gen clk_gen_i (
      .sram_clk_o (sram_clk),
      .resetn_o   (resetn)
   );

   sram_test_top dut_i (
      .sram_clk  (sram_clk),
      .resetn    (resetn),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr)
   );

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_slverr(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %b actual %b", $time, name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_busy(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %b actual %b", $time, name, expected, actual);
         stop_run();
      end
   endtask

   // starts 1 ns after an edge, ends 1 ns after the edge that completes it
   task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                               input data_t wdata, output data_t rdata, output logic slverr);
      int waited;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge sram_clk);
      #1;
      penable = 1'b1;
      waited  = 0;
      @(negedge sram_clk);
      while (!pready) begin
         waited++;
         if (waited > ready_limit) begin
            $display("Timeout: pready_o stayed low in an APB access phase");
            stop_run();
         end
         @(negedge sram_clk);
      end
      rdata  = prdata;
      slverr = pslverr;
      @(posedge sram_clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input logic [apb_addr_w-1:0] addr, input data_t data,
                            input logic exp_err);
      data_t rdata;
      logic  err;
      apb_transfer(1'b1, addr, data, rdata, err);
      check_slverr("pslverr_o", exp_err, err);
   endtask

   task automatic read_reg(input logic [apb_addr_w-1:0] addr, input logic exp_err,
                           output data_t data);
      logic err;
      apb_transfer(1'b0, addr, '0, data, err);
      check_slverr("pslverr_o", exp_err, err);
   endtask

   task automatic wait_reset();
      int cycles;
      cycles = 0;
      while (resetn !== 1'b1) begin
         cycles++;
         if (cycles > reset_limit) begin
            $display("Timeout: resetn was never released");
            stop_run();
         end
         @(negedge sram_clk);
      end
      @(posedge sram_clk);
      #1;
   endtask

   task automatic wait_idle();
      data_t status;
      int    polls;
      polls = 0;
      read_reg(reg_status_off, 1'b0, status);
      while (status[status_busy_bit]) begin
         polls++;
         if (polls > poll_limit) begin
            $display("Timeout: STATUS busy did not clear after a CMD write");
            stop_run();
         end
         read_reg(reg_status_off, 1'b0, status);
      end
   endtask

   task automatic check_reset_state();
      data_t rdata;
      read_reg(reg_status_off, 1'b0, rdata);
      check_busy("STATUS busy", 1'b0, rdata[status_busy_bit]);
      read_reg(reg_dout0_off, 1'b0, rdata);
      check_data("DOUT0", 32'h0, rdata);
      read_reg(reg_dout1_off, 1'b0, rdata);
      check_data("DOUT1", 32'h0, rdata);
      // remaining mapped offsets answer without error
      read_reg(reg_addr_off, 1'b0, rdata);
      read_reg(reg_din_off, 1'b0, rdata);
      read_reg(reg_ctrl_off, 1'b0, rdata);
      read_reg(reg_cmd_off, 1'b0, rdata);
   endtask

   task automatic check_unmapped();
      data_t rdata;
      write_reg(12'h01C, 32'h1, 1'b1);
      write_reg(12'h006, 32'h1, 1'b1);
      read_reg(12'h020, 1'b1, rdata);
      read_reg(12'hFFC, 1'b1, rdata);
      read_reg(reg_status_off, 1'b0, rdata);
      check_busy("STATUS busy", 1'b0, rdata[status_busy_bit]);
   endtask

   task automatic run_access(input logic [3:0] op, input chip_t chip, input sram_addr_t a0,
                             input sram_addr_t a1, input data_t data, input wmask_t mask,
                             input data_t exp0, input data_t exp1);
      data_t ctrl;
      data_t rdata;
      ctrl                          = '0;
      ctrl[ctrl_mask_lsb +: mask_w] = mask;
      ctrl[ctrl_read_bit]           = (op == 4'd1) || (op == 4'd3);
      ctrl[ctrl_chip_lsb +: chip_w] = chip;
      write_reg(reg_addr_off, {6'd0, a1, 6'd0, a0}, 1'b0);
      write_reg(reg_din_off, data, 1'b0);
      write_reg(reg_ctrl_off, ctrl, 1'b0);
      // configuration reads back as written
      read_reg(reg_addr_off, 1'b0, rdata);
      check_data("ADDR", {6'd0, a1, 6'd0, a0}, rdata);
      read_reg(reg_din_off, 1'b0, rdata);
      check_data("DIN", data, rdata);
      read_reg(reg_ctrl_off, 1'b0, rdata);
      check_data("CTRL", ctrl, rdata);
      write_reg(reg_cmd_off, 32'h1, 1'b0);
      if (op == 4'd3) begin
         // lands while the first access is still in flight
         write_reg(reg_cmd_off, 32'h1, 1'b1);
      end else begin
         read_reg(reg_status_off, 1'b0, rdata);
         check_busy("STATUS busy", 1'b1, rdata[status_busy_bit]);
      end
      wait_idle();
      read_reg(reg_dout0_off, 1'b0, rdata);
      check_data("DOUT0", exp0, rdata);
      if (op != 4'd2) begin
         read_reg(reg_dout1_off, 1'b0, rdata);
         check_data("DOUT1", exp1, rdata);
      end
   endtask

   task automatic run_vectors();
      int               fd;
      int               count;
      int               n_vec;
      logic [8*160-1:0] line;
      logic [3:0]       op;
      chip_t            chip;
      sram_addr_t       a0;
      sram_addr_t       a1;
      data_t            data;
      wmask_t           mask;
      data_t            exp0;
      data_t            exp1;
      n_vec = 0;
      fd    = $fopen("verif/sram_test_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file verif/sram_test_input.txt");
         stop_run();
      end
      while (!$feof(fd)) begin
         line  = '0;
         count = $fgets(line, fd);
         // comment and blank lines do not scan
         if (count > 0) begin
            count = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            op, chip, a0, a1, data, mask, exp0, exp1);
            if (count == 8) begin
               run_access(op, chip, a0, a1, data, mask, exp0, exp1);
               n_vec++;
            end
         end
      end
      $fclose(fd);
      if (n_vec == 0) begin
         $display("The vector file held no vectors");
         stop_run();
      end
   endtask

   initial begin
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      wait_reset();
      check_reset_state();
      check_unmapped();
      run_vectors();
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/sram_test_input.txt
# op chip addr0 addr1 data mask exp_dout0 exp_dout1, all hex
# op 0 write, 1 read, 2 write with dout1 unchecked, 3 read with a CMD while busy
# chip 1, fill then byte mask 0101, port 1 old contents on same address
2 1 010 010 11223344 f 00000000 00000000
2 1 020 020 aabbccdd f 00000000 00000000
0 1 010 020 55667788 5 00000000 aabbccdd
1 1 010 020 00000000 0 11663388 aabbccdd
0 1 020 020 01020304 f 00000000 aabbccdd
1 1 020 010 00000000 0 01020304 11663388
# chip 2
2 2 1ff 1ff deadbeef f 00000000 00000000
2 2 100 100 cafef00d f 00000000 00000000
0 2 1ff 100 12345678 a 00000000 cafef00d
1 2 1ff 100 00000000 0 12ad56ef cafef00d
# chip 0 is 8 bits wide, mask bit 0 only
2 0 3ff 3ff a5a5a5c3 1 00000000 00000000
2 0 001 001 ffffff7e f 00000000 00000000
1 0 3ff 001 00000000 0 000000c3 0000007e
0 0 001 3ff 00000011 e 00000000 000000c3
1 0 001 001 00000000 0 0000007e 0000007e
# chip 3 single port
0 3 005 000 87654321 f 00000000 00000000
0 3 005 000 0000aa00 2 00000000 00000000
1 3 005 3ff 00000000 0 8765aa21 00000000
# chip 4, mask bits 3:2 to bytes 7:6, bits 1:0 to bytes 1:0
0 4 1a0 000 fedcba98 f 00000000 00000000
1 4 1a0 000 00000000 0 fedcba98 00000000
0 4 1a0 000 01234567 4 00000000 00000000
0 4 1a0 000 01234567 1 00000000 00000000
1 4 1a0 000 00000000 0 fe23ba67 00000000
0 4 1a0 000 a0b0c0d0 a 00000000 00000000
1 4 1a0 000 00000000 0 a023c067 00000000
# empty chips 5 to 7, then the populated chips are unchanged
0 5 010 020 ffffffff f 00000000 00000000
1 6 010 020 00000000 0 00000000 00000000
0 7 1ff 100 ffffffff f 00000000 00000000
1 7 1a0 1a0 00000000 0 00000000 00000000
1 1 010 020 00000000 0 11663388 01020304
1 2 1ff 100 00000000 0 12ad56ef cafef00d
1 3 005 000 00000000 0 8765aa21 00000000
1 4 1a0 000 00000000 0 a023c067 00000000
# rejected CMD while busy, the first access keeps its result
3 1 020 010 00000000 0 01020304 11663388
3 4 1a0 000 00000000 0 a023c067 00000000

// File: compile.f
logic/sram_test_pkg.sv
logic/sram_1rw1r.sv
logic/sram_1rw.sv
logic/sram_dual_bank.sv
logic/sram_single_bank.sv
logic/sram_apb_regs.sv
logic/sram_test_top.sv
verif/tb_clk_gen.sv
verif/sram_test_sva.sv
verif/sram_test_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the SRAM harness testbench with Verilator and runs it
# exits non-zero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f compile.f \
   --top-module sram_test_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/Vsram_test_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "All checks passed" "$log_file"; then
   exit 0
else
   echo "Pass line not found in $log_file"
   exit 1
fi
